//--- rtl/victim_cache_pkg.sv
package victim_cache_pkg;

    // queue geometry
    localparam int vic_size = 4;
    localparam int vic_bits = 2;

    // probe ports and insert/evict ports
    localparam int rd_ports = 2;
    localparam int wr_ports = 3;

    // L1 address split and payload width
    localparam int set_bits  = 5;
    localparam int tag_bits  = 8;
    localparam int data_bits = 64;

    // probe compare key is tag followed by set index
    localparam int key_bits = tag_bits + set_bits;

    // one 73-bit L1 line as it leaves the data cache
    typedef struct packed {
        logic                 valid;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] data;
    } cache_line_t;

    // one 78-bit queue slot or evicted line
    // the set index travels with the line since the queue is fully associative
    typedef struct packed {
        cache_line_t          line;
        logic [set_bits-1:0]  idx;
    } vic_entry_t;

    // cleared slot with line.valid low
    localparam vic_entry_t empty_entry = '0;

endpackage

//--- rtl/vic_lookup.sv
`timescale 1ns/1ps

module vic_lookup import victim_cache_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [rd_ports-1:0]                  rd_en,
    input  logic [rd_ports-1:0][set_bits-1:0]    rd_idx,
    input  logic [rd_ports-1:0][tag_bits-1:0]    rd_tag,
    input  vic_entry_t [vic_size-1:0]            entries,
    output logic [rd_ports-1:0]                  rd_valid,
    output vic_entry_t [rd_ports-1:0]            rd_entry,
    output logic [vic_size-1:0]                  hit_mask
);

    logic [rd_ports-1:0][key_bits-1:0] probe_key;
    logic [vic_size-1:0][key_bits-1:0] entry_key;
    logic [rd_ports-1:0][vic_size-1:0] match;
    logic [rd_ports-1:0][vic_bits-1:0] rd_sel;

    // build compare keys
    always_comb begin
        for (int p = 0; p < rd_ports; p++) begin
            probe_key[p] = {rd_tag[p], rd_idx[p]};
        end
        for (int e = 0; e < vic_size; e++) begin
            entry_key[e] = {entries[e].line.tag, entries[e].idx};
        end
    end

    // associative compare, only valid lines can hit
    always_comb begin
        for (int p = 0; p < rd_ports; p++) begin
            for (int e = 0; e < vic_size; e++) begin
                match[p][e] = rd_en[p] && entries[e].line.valid &&
                              (probe_key[p] == entry_key[e]);
            end
        end
    end

    // priority encode, lowest slot (oldest) wins
    always_comb begin
        hit_mask = '0;
        for (int p = 0; p < rd_ports; p++) begin
            rd_sel[p]   = '0;
            rd_valid[p] = |match[p];
            for (int e = vic_size - 1; e >= 0; e--) begin
                if (match[p][e]) begin
                    rd_sel[p] = vic_bits'(e);
                end
            end
            rd_entry[p] = rd_valid[p] ? entries[rd_sel[p]] : empty_entry;
            // any hit on any port pulls the slot out of the queue
            hit_mask = hit_mask | match[p];
        end
    end

    // upstream never inserts a duplicate address, so at most one slot matches
    for (genvar p = 0; p < rd_ports; p++) begin : g_match_check
        match_onehot_a: assert property (
            @(posedge clock) disable iff (reset)
            $onehot0(match[p])
        );
    end

endmodule

//--- rtl/victim_queue.sv
`timescale 1ns/1ps

module victim_queue import victim_cache_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [vic_size-1:0]                  hit_mask,
    input  logic [wr_ports-1:0]                  wr_valid,
    input  logic [wr_ports-1:0][set_bits-1:0]    wr_idx,
    input  cache_line_t [wr_ports-1:0]           wr_line,
    output vic_entry_t [vic_size-1:0]            entries,
    output logic [wr_ports-1:0]                  evict_valid,
    output vic_entry_t [wr_ports-1:0]            evict_entry
);

    // occupancy, one bit wider than an index so a full queue fits
    logic [vic_bits:0]         count_q;
    logic [vic_bits:0]         count_next;

    vic_entry_t [vic_size-1:0] survivors;
    vic_entry_t [vic_size-1:0] entries_next;
    logic [vic_bits:0]         live_count;
    logic [vic_bits:0]         num_writes;
    logic [vic_bits:0]         free_slots;
    logic [vic_bits:0]         num_evict;

    always_comb begin
        int src;

        // drop hit slots and close the gaps in age order
        for (int e = 0; e < vic_size; e++) begin
            survivors[e] = empty_entry;
        end
        live_count = '0;
        for (int e = 0; e < vic_size; e++) begin
            if (((vic_bits + 1)'(e) < count_q) && !hit_mask[e]) begin
                survivors[live_count[vic_bits-1:0]] = entries[e];
                live_count = live_count + 1'b1;
            end
        end

        // make room for this cycle's writes
        num_writes = '0;
        for (int w = 0; w < wr_ports; w++) begin
            num_writes = num_writes + (vic_bits + 1)'(wr_valid[w]);
        end
        free_slots = (vic_bits + 1)'(vic_size) - live_count;
        num_evict  = (num_writes > free_slots) ? num_writes - free_slots : '0;

        // oldest survivors go out on evict ports 0 upward
        for (int w = 0; w < wr_ports; w++) begin
            evict_valid[w] = ((vic_bits + 1)'(w) < num_evict);
            evict_entry[w] = evict_valid[w] ? survivors[w] : empty_entry;
        end

        // shift the rest down past the evicted ones
        for (int e = 0; e < vic_size; e++) begin
            src = e + int'(num_evict);
            if (src < vic_size) begin
                entries_next[e] = survivors[src];
            end else begin
                entries_next[e] = empty_entry;
            end
        end
        count_next = live_count - num_evict;

        // append writes at the tail with port 0 first
        // num_evict guarantees the tail index stays below vic_size here
        for (int w = 0; w < wr_ports; w++) begin
            if (wr_valid[w]) begin
                entries_next[count_next[vic_bits-1:0]].line = wr_line[w];
                entries_next[count_next[vic_bits-1:0]].idx  = wr_idx[w];
                count_next = count_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < vic_size; e++) begin
                entries[e] <= empty_entry;
            end
            count_q <= '0;
        end else begin
            entries <= entries_next;
            count_q <= count_next;
        end
    end

    // occupancy bound
    count_in_range_a: assert property (
        @(posedge clock) disable iff (reset)
        count_q <= (vic_bits + 1)'(vic_size)
    );

    // slots past the tail stay cleared, lookup relies on their valid bit
    for (genvar e = 0; e < vic_size; e++) begin : g_tail_check
        tail_empty_a: assert property (
            @(posedge clock) disable iff (reset)
            ((vic_bits + 1)'(e) >= count_q) |-> (entries[e] == empty_entry)
        );
    end

    // each eviction is caused by a write
    evict_bound_a: assert property (
        @(posedge clock) disable iff (reset)
        $countones(evict_valid) <= $countones(wr_valid)
    );

endmodule

//--- rtl/victim_cache_top.sv
`timescale 1ns/1ps

module victim_cache_top import victim_cache_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,

    // insert side, port 0 oldest within a cycle
    input  logic [wr_ports-1:0]                  wr_valid,
    input  logic [wr_ports-1:0][set_bits-1:0]    wr_idx,
    input  cache_line_t [wr_ports-1:0]           wr_line,

    // probe side
    input  logic [rd_ports-1:0]                  rd_en,
    input  logic [rd_ports-1:0][set_bits-1:0]    rd_idx,
    input  logic [rd_ports-1:0][tag_bits-1:0]    rd_tag,

    // probe results, same cycle as rd_en
    output logic [rd_ports-1:0]                  rd_valid,
    output vic_entry_t [rd_ports-1:0]            rd_entry,

    // lines pushed out by overflow, same cycle as wr_valid
    output logic [wr_ports-1:0]                  evict_valid,
    output vic_entry_t [wr_ports-1:0]            evict_entry
);

    vic_entry_t [vic_size-1:0] entries;
    logic [vic_size-1:0]       hit_mask;

    vic_lookup lookup_i (
        .clock    (clock),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_tag   (rd_tag),
        .entries  (entries),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry),
        .hit_mask (hit_mask)
    );

    victim_queue queue_i (
        .clock       (clock),
        .reset       (reset),
        .hit_mask    (hit_mask),
        .wr_valid    (wr_valid),
        .wr_idx      (wr_idx),
        .wr_line     (wr_line),
        .entries     (entries),
        .evict_valid (evict_valid),
        .evict_entry (evict_entry)
    );

endmodule

//--- test/victim_model.svh
`ifndef VICTIM_MODEL_SVH
`define VICTIM_MODEL_SVH

// everything the testbench drives into the DUT in one cycle
typedef struct packed {
    logic [wr_ports-1:0]               wr_valid;
    logic [wr_ports-1:0][set_bits-1:0] wr_idx;
    cache_line_t [wr_ports-1:0]        wr_line;
    logic [rd_ports-1:0]               rd_en;
    logic [rd_ports-1:0][set_bits-1:0] rd_idx;
    logic [rd_ports-1:0][tag_bits-1:0] rd_tag;
} stim_t;

// expected DUT outputs for one cycle
typedef struct packed {
    logic [rd_ports-1:0]        rd_valid;
    vic_entry_t [rd_ports-1:0]  rd_entry;
    logic [wr_ports-1:0]        evict_valid;
    vic_entry_t [wr_ports-1:0]  evict_entry;
} expect_t;

typedef vic_entry_t entry_q_t[$];

// model queue, index 0 is the oldest entry
vic_entry_t model_q[$];

function automatic bit port_match(input stim_t s, input int p, input vic_entry_t e);
    return s.rd_en[p] && e.line.valid && (e.line.tag == s.rd_tag[p]) &&
           (e.idx == s.rd_idx[p]);
endfunction

// entries that no probe port hits this cycle, age order kept
function automatic entry_q_t survivors_of(input stim_t s);
    entry_q_t surv;
    bit hit;
    foreach (model_q[i]) begin
        hit = 1'b0;
        for (int p = 0; p < rd_ports; p++) begin
            if (port_match(s, p, model_q[i])) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            surv.push_back(model_q[i]);
        end
    end
    return surv;
endfunction

function automatic int evict_count(input stim_t s, input int live);
    int n;
    n = 0;
    for (int w = 0; w < wr_ports; w++) begin
        n += int'(s.wr_valid[w]);
    end
    n = n - (vic_size - live);
    return (n > 0) ? n : 0;
endfunction

function automatic expect_t expected_outputs(input stim_t s);
    expect_t x;
    entry_q_t surv;
    int n_ev;
    x = '0;
    // oldest matching entry wins
    for (int p = 0; p < rd_ports; p++) begin
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (port_match(s, p, model_q[i])) begin
                x.rd_valid[p] = 1'b1;
                x.rd_entry[p] = model_q[i];
            end
        end
    end
    surv = survivors_of(s);
    n_ev = evict_count(s, surv.size());
    for (int w = 0; w < n_ev; w++) begin
        x.evict_valid[w] = 1'b1;
        x.evict_entry[w] = surv[w];
    end
    return x;
endfunction

// one clock edge: remove hits, evict oldest, append writes
function automatic void apply_update(input stim_t s);
    entry_q_t surv;
    int n_ev;
    vic_entry_t e;
    surv = survivors_of(s);
    n_ev = evict_count(s, surv.size());
    repeat (n_ev) begin
        void'(surv.pop_front());
    end
    for (int w = 0; w < wr_ports; w++) begin
        if (s.wr_valid[w]) begin
            e.line = s.wr_line[w];
            e.idx  = s.wr_idx[w];
            surv.push_back(e);
        end
    end
    model_q = surv;
endfunction

`endif

//--- test/victim_cache_tb.sv
`timescale 1ns/1ps

module victim_cache_tb import victim_cache_pkg::*; ();

    `include "victim_model.svh"

    localparam int clock_period   = 10;
    localparam int random_cycles  = 2000;
    localparam int planned_cycles = 5 + 12 + random_cycles;

    logic clock = 1'b0;
    logic reset;
    stim_t stim;
    expect_t exp_out;
    int key_count = 0;

    logic [rd_ports-1:0]       rd_valid;
    vic_entry_t [rd_ports-1:0] rd_entry;
    logic [wr_ports-1:0]       evict_valid;
    vic_entry_t [wr_ports-1:0] evict_entry;

    victim_cache_top dut_i (
        .clock       (clock),
        .reset       (reset),
        .wr_valid    (stim.wr_valid),
        .wr_idx      (stim.wr_idx),
        .wr_line     (stim.wr_line),
        .rd_en       (stim.rd_en),
        .rd_idx      (stim.rd_idx),
        .rd_tag      (stim.rd_tag),
        .rd_valid    (rd_valid),
        .rd_entry    (rd_entry),
        .evict_valid (evict_valid),
        .evict_entry (evict_entry)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // odd multiplier keeps every key unique until the counter wraps
    function automatic vic_entry_t fresh_entry();
        vic_entry_t e;
        logic [key_bits-1:0] key;
        key = key_bits'(key_count * 1237);
        key_count++;
        e.line.valid = 1'b1;
        e.line.tag   = key[key_bits-1:set_bits];
        e.idx        = key[set_bits-1:0];
        e.line.data  = {$urandom(), $urandom()};
        return e;
    endfunction

    function automatic void put_write(inout stim_t s, input int port, input vic_entry_t e);
        s.wr_valid[port] = 1'b1;
        s.wr_idx[port]   = e.idx;
        s.wr_line[port]  = e.line;
    endfunction

    function automatic void put_probe(inout stim_t s, input int port, input vic_entry_t e);
        s.rd_en[port]  = 1'b1;
        s.rd_idx[port] = e.idx;
        s.rd_tag[port] = e.line.tag;
    endfunction

    // built after the model has taken the last edge
    function automatic stim_t random_stim();
        stim_t s;
        vic_entry_t e;
        int pick;
        s = '0;
        for (int w = 0; w < wr_ports; w++) begin
            if ($urandom_range(0, 99) < 40) begin
                put_write(s, w, fresh_entry());
            end
        end
        for (int p = 0; p < rd_ports; p++) begin
            pick = $urandom_range(0, 3);
            if (pick != 0 && pick <= 2 && model_q.size() > 0) begin
                put_probe(s, p, model_q[$urandom_range(0, model_q.size() - 1)]);
            end else if (pick == 3) begin
                e = '0;
                e.line.tag = tag_bits'($urandom());
                e.idx      = set_bits'($urandom());
                put_probe(s, p, e);
            end
        end
        return s;
    endfunction

    task automatic drive(input stim_t s);
        @(posedge clock);
        #1;
        stim = s;
    endtask

    // compare just before the edge, then step the model with the same inputs
    always begin
        @(posedge clock);
        #9;
        if (reset) begin
            model_q.delete();
        end else begin
            exp_out = expected_outputs(stim);
            check_value("rd_valid", rd_valid, exp_out.rd_valid);
            for (int p = 0; p < rd_ports; p++) begin
                check_value($sformatf("rd_entry[%0d]", p), rd_entry[p], exp_out.rd_entry[p]);
            end
            check_value("evict_valid", evict_valid, exp_out.evict_valid);
            for (int w = 0; w < wr_ports; w++) begin
                check_value($sformatf("evict_entry[%0d]", w), evict_entry[w],
                            exp_out.evict_entry[w]);
            end
            apply_update(stim);
        end
    end

    initial begin
        #(2 * planned_cycles * clock_period);
        $display("timeout, the test did not finish within %0d cycles", 2 * planned_cycles);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        vic_entry_t a[11];
        stim_t s;
        reset = 1'b1;
        stim  = '0;
        void'($urandom(36));
        for (int i = 0; i < 11; i++) begin
            a[i] = fresh_entry();
        end
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // empty queue misses
        s = '0;
        put_probe(s, 0, a[0]);
        put_probe(s, 1, a[1]);
        drive(s);
        #7;
        check_value("rd_valid", rd_valid, 2'b00);

        // fill with four lines over two cycles
        s = '0;
        put_write(s, 0, a[0]);
        put_write(s, 1, a[1]);
        drive(s);
        s = '0;
        put_write(s, 0, a[2]);
        put_write(s, 2, a[3]);
        drive(s);

        s = '0;
        put_probe(s, 0, a[4]);
        put_probe(s, 1, a[2]);
        drive(s);
        #7;
        check_value("rd_valid", rd_valid, 2'b10);
        check_value("rd_entry[1]", rd_entry[1], a[2]);

        // hit entry is gone and a3 moves up
        s = '0;
        put_probe(s, 0, a[2]);
        drive(s);
        #7;
        check_value("rd_valid", rd_valid, 2'b00);
        check_value("entries[2]", dut_i.entries[2], a[3]);

        s = '0;
        put_write(s, 1, a[4]);
        drive(s);

        // three writes into a full queue push out the three oldest
        s = '0;
        put_write(s, 0, a[5]);
        put_write(s, 1, a[6]);
        put_write(s, 2, a[7]);
        drive(s);
        #7;
        check_value("evict_valid", evict_valid, 3'b111);
        check_value("evict_entry[0]", evict_entry[0], a[0]);
        check_value("evict_entry[1]", evict_entry[1], a[1]);
        check_value("evict_entry[2]", evict_entry[2], a[3]);

        // two hits free room first so only one eviction is left
        s = '0;
        put_probe(s, 0, a[5]);
        put_probe(s, 1, a[6]);
        put_write(s, 0, a[8]);
        put_write(s, 1, a[9]);
        put_write(s, 2, a[10]);
        drive(s);
        #7;
        check_value("rd_valid", rd_valid, 2'b11);
        check_value("evict_valid", evict_valid, 3'b001);
        check_value("evict_entry[0]", evict_entry[0], a[4]);

        repeat (random_cycles) begin
            @(posedge clock);
            #1;
            stim = random_stim();
        end

        drive('0);
        @(posedge clock);
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- victim_cache_top.f
+incdir+test
rtl/victim_cache_pkg.sv
rtl/vic_lookup.sv
rtl/victim_queue.sv
rtl/victim_cache_top.sv
test/victim_cache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := victim_cache_tb
RTL_TOP    := victim_cache_top
FILELIST   := victim_cache_top.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
